//--- Bender.yml
package:
  name: fetch_cache

sources:
  - fetch_cache_pkg.sv
  - fetch_cache_ctrl.sv
  - fetch_cache_mem.sv
  - fetch_cache_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_fetch_cache.sv

//--- fetch_cache.f
fetch_cache_pkg.sv
fetch_cache_ctrl.sv
fetch_cache_mem.sv
fetch_cache_top.sv
tb_mem_model.sv
tb_fetch_cache.sv

//--- fetch_cache_ctrl.sv
// Fetch cache miss controller
module fetch_cache_ctrl
  import fetch_cache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  fetch_addr_u  fetch_addr,
  input  logic         hit,
  input  mem_reply_s   mem_reply,
  output mem_request_s mem_request,
  output line_fill_s   line_fill
);

  logic [index_bits-1:0]   last_index;            // Index seen in the previous cycle.
  logic [tag_bits-1:0]     last_tag;              // Tag seen in the previous cycle.
  logic [mem_tag_bits-1:0] current_mem_tag;       // Transaction we are waiting on.
  logic [mem_tag_bits-1:0] next_mem_tag;
  logic                    miss_outstanding;      // A load still has to be accepted.
  logic                    changed_addr;
  logic                    send_request;
  logic                    fill_now;
  logic                    update_mem_tag;
  logic                    unanswered_miss;

  // A new address shows up as a different index or tag from last cycle.
  assign changed_addr = (fetch_addr.fields.index != last_index) ||
                        (fetch_addr.fields.tag != last_tag);

  // The request is only repeated while the address holds still.
  assign send_request = miss_outstanding && !changed_addr;

  assign mem_request.command = send_request ? bus_load : bus_none;
  assign mem_request.addr    = {fetch_addr.raw[63:offset_bits], {offset_bits{1'b0}}};

  // Returning data is ours when it carries the tag we were granted.
  assign fill_now = (current_mem_tag != '0) &&
                    (current_mem_tag == mem_reply.tag) &&
                    !changed_addr;                // Never write into a line we just left.

  assign line_fill.write = fill_now;
  assign line_fill.index = fetch_addr.fields.index;
  assign line_fill.tag   = fetch_addr.fields.tag;
  assign line_fill.data  = mem_reply.data;

  assign update_mem_tag = changed_addr || miss_outstanding || fill_now;

  always_comb begin
    // A grant only counts while we are actually asking, so a change clears the tag.
    if (send_request) begin
      next_mem_tag = mem_reply.response;
    end else begin
      next_mem_tag = '0;
    end

    // On a change the miss depends on the lookup, otherwise on the memory answer.
    if (changed_addr) begin
      unanswered_miss = !hit;
    end else begin
      unanswered_miss = miss_outstanding && (mem_reply.response == '0);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      last_index       <= '1;                     // All ones, so the first address is new.
      last_tag         <= '1;
      current_mem_tag  <= '0;
      miss_outstanding <= 1'b0;
    end else begin
      last_index       <= fetch_addr.fields.index;
      last_tag         <= fetch_addr.fields.tag;
      miss_outstanding <= unanswered_miss;
      if (update_mem_tag) begin
        current_mem_tag <= next_mem_tag;
      end
    end
  end

  // A load goes out only for a line that still misses and never as the processor moves.
  assert property (@(posedge clock) disable iff (reset)
    (mem_request.command == bus_load) |-> !changed_addr && !hit);

  // A fill needs a transaction that was granted in an earlier cycle.
  assert property (@(posedge clock) disable iff (reset)
    line_fill.write |-> (current_mem_tag != '0) && !miss_outstanding);

endmodule

//--- fetch_cache_mem.sv
// Fetch cache line storage
module fetch_cache_mem
  import fetch_cache_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_addr_u          lookup_addr,
  input  line_fill_s           line_fill,
  output logic                 hit,
  output logic [line_bits-1:0] line_data
);

  logic [line_bits-1:0] data_array [line_count];  // Line contents.
  logic [tag_bits-1:0]  tag_array [line_count];   // Address tag of each line.
  logic [line_count-1:0] valid_bits;              // One bit per line.
  logic [index_bits-1:0] lookup_index;
  logic [tag_bits-1:0]   stored_tag;

  assign lookup_index = lookup_addr.fields.index;
  assign stored_tag   = tag_array[lookup_index];

  // The lookup is combinational so a hit shows in the same cycle.
  assign hit       = valid_bits[lookup_index] && (stored_tag == lookup_addr.fields.tag);
  assign line_data = data_array[lookup_index];

  // Valid bits are the only state that needs a known value after reset.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (line_fill.write) begin
      valid_bits[line_fill.index] <= 1'b1;
    end
  end

  // Data and tag are written together at the filled index.
  always_ff @(posedge clock) begin
    if (line_fill.write) begin
      data_array[line_fill.index] <= line_fill.data;
      tag_array[line_fill.index]  <= line_fill.tag;
    end
  end

  // Nothing can hit until a fill has happened after reset.
  assert property (@(posedge clock) reset |=> !hit);

endmodule

//--- fetch_cache_pkg.sv
// Fetch cache shared types
package fetch_cache_pkg;

  // Cache geometry.
  localparam int line_bits    = 64;                   // One line is one 64-bit word.
  localparam int offset_bits  = 3;                    // Byte offset inside a line.
  localparam int index_bits   = 5;                    // Selects one of 32 lines.
  localparam int tag_bits     = 8;                    // Address tag kept per line.
  localparam int line_count   = 1 << index_bits;
  localparam int upper_bits   = 64 - tag_bits - index_bits - offset_bits;
  localparam int mem_tag_bits = 4;                    // Memory transaction tag width.

  // Memory bus command.
  typedef enum logic [1:0] {
    bus_none  = 2'b00,
    bus_load  = 2'b01,
    bus_store = 2'b10                                 // Reserved, the fetch path never writes.
  } bus_command_e;

  // Fetch address split into cache fields.
  typedef struct packed {
    logic [upper_bits-1:0]  upper;                    // Not part of the lookup.
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
  } fetch_addr_fields_s;

  // The same address word, seen whole or split into fields.
  typedef union packed {
    logic [63:0]        raw;
    fetch_addr_fields_s fields;
  } fetch_addr_u;

  // Request from the cache toward memory.
  typedef struct packed {
    bus_command_e command;
    logic [63:0]  addr;                               // Always line-aligned.
  } mem_request_s;

  // Reply from memory toward the cache.
  typedef struct packed {
    logic [mem_tag_bits-1:0] response;                // Granted tag, zero when refused.
    logic [line_bits-1:0]    data;
    logic [mem_tag_bits-1:0] tag;                     // Tag of returning data, zero for none.
  } mem_reply_s;

  // Line write from the controller into the storage.
  typedef struct packed {
    logic                  write;
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic [line_bits-1:0]  data;
  } line_fill_s;

endpackage

//--- fetch_cache_top.sv
// Instruction fetch cache top
module fetch_cache_top
  import fetch_cache_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_addr_u          fetch_addr,
  input  mem_reply_s           mem_reply,
  output logic [line_bits-1:0] fetch_data,
  output logic                 fetch_valid,
  output mem_request_s         mem_request
);

  logic                 hit;                      // Lookup result from the storage.
  logic [line_bits-1:0] line_data;                // Line at the current index.
  line_fill_s           line_fill;                // Write from the controller.

  // The processor sees the storage lookup directly.
  assign fetch_valid = hit;
  assign fetch_data  = line_data;

  fetch_cache_ctrl fetch_cache_ctrl_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .hit         (hit),
    .mem_reply   (mem_reply),
    .mem_request (mem_request),
    .line_fill   (line_fill)
  );

  fetch_cache_mem fetch_cache_mem_i (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (fetch_addr),
    .line_fill   (line_fill),
    .hit         (hit),
    .line_data   (line_data)
  );

endmodule

//--- tb_fetch_cache.sv
// Fetch cache testbench
module tb_fetch_cache
  import fetch_cache_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period  = 20;
  localparam int drive_delay  = 2;           // Inputs change this long after the edge.
  localparam int reset_cycles = 8;
  localparam int wait_limit   = 100;         // Cycles before a wait gives up.
  localparam int cond_valid   = 0;
  localparam int cond_load    = 1;
  localparam int cond_grant   = 2;

  localparam logic [63:0] addr_a = 64'h0000_0012_3456_78ad;  // Index 21, odd offset.
  localparam logic [63:0] addr_b = 64'h0000_0012_3456_7840;  // Index 8.
  localparam logic [63:0] addr_c = 64'h0000_0012_3456_79ad;  // Index 21, other tag.
  localparam logic [63:0] addr_d = 64'h0000_00ab_cdef_0118;  // Index 3.
  localparam logic [63:0] addr_e = 64'h0000_0000_0000_5a60;  // Index 12.
  localparam logic [63:0] addr_f = 64'h0000_0000_0000_a5f0;  // Index 30.

  logic                 clock;
  logic                 reset;
  fetch_addr_u          fetch_addr;
  mem_reply_s           mem_reply;
  mem_request_s         mem_request;
  logic [line_bits-1:0] fetch_data;
  logic                 fetch_valid;
  logic                 force_refuse;
  logic                 expect_hit;        // Set while the current address must hit.
  int                   error_count;
  int                   test_count;

  fetch_cache_top fetch_cache_top_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_reply   (mem_reply),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .mem_request (mem_request)
  );

  tb_mem_model tb_mem_model_i (
    .clock        (clock),
    .reset        (reset),
    .force_refuse (force_refuse),
    .mem_request  (mem_request),
    .mem_reply    (mem_reply)
  );

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // Memory content of the line that holds a byte address.
  function automatic logic [63:0] expected_line(input logic [63:0] addr);
    return {addr[63:3], 3'b000} ^ 64'h5a5a_0000_c3c3_0000;
  endfunction

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("mismatch at %0d ns: %s", $time, msg);
  endtask

  // The bus is idle and nothing hits right after reset.
  assert property (@(posedge clock)
    reset |=> (mem_request.command == bus_none) && !fetch_valid)
    else report_mismatch("bus busy or fetch_valid high after reset");

  assert property (@(posedge clock) disable iff (reset)
    fetch_valid |-> (fetch_data == expected_line(fetch_addr.raw)))
    else report_mismatch($sformatf("fetch_data %h for address %h",
                                   $sampled(fetch_data), $sampled(fetch_addr.raw)));

  // Loads ask for the aligned line that contains the current fetch address.
  assert property (@(posedge clock) disable iff (reset)
    (mem_request.command == bus_load) |->
      (mem_request.addr[2:0] == 3'b000) && (fetch_addr.raw - mem_request.addr < 64'd8))
    else report_mismatch($sformatf("load address %h", $sampled(mem_request.addr)));

  assert property (@(posedge clock) disable iff (reset)
    fetch_valid |-> (mem_request.command != bus_load))
    else report_mismatch("bus load while the line hits");

  assert property (@(posedge clock) disable iff (reset)
    expect_hit |-> fetch_valid)
    else report_mismatch("filled line did not hit");

  // A refused load is repeated while the processor holds its address.
  assert property (@(posedge clock) disable iff (reset)
    ((mem_request.command == bus_load) && (mem_reply.response == '0))
      ##1 $stable(fetch_addr.raw)
      |-> (mem_request.command == bus_load) && $stable(mem_request.addr))
    else report_mismatch("refused load was not repeated");

  assert property (@(posedge clock) disable iff (reset)
    ((mem_request.command == bus_load) && (mem_reply.response != '0))
      |=> (mem_request.command != bus_load))
    else report_mismatch("load repeated after a grant");

  assert property (@(posedge clock) disable iff (reset)
    mem_request.command != bus_store)
    else report_mismatch("store issued on the fetch path");

  function automatic bit condition_met(input int kind);
    case (kind)
      cond_valid: return fetch_valid;
      cond_load:  return mem_request.command == bus_load;
      default:    return (mem_request.command == bus_load) && (mem_reply.response != '0);
    endcase
  endfunction

  // Looks at the outputs on falling edges, away from any input change.
  task automatic wait_for(input int kind, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!condition_met(kind) && (cycles < wait_limit));
    if (!condition_met(kind)) begin
      error_count++;
      $display("%0d ns: gave up after %0d cycles waiting for %s", $time, wait_limit, what);
    end
  endtask

  task automatic next_cycle(input int count);
    repeat (count) @(posedge clock);
    #drive_delay;
  endtask

  task automatic end_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("%0d ns: test %s ok", $time, name);
    end else begin
      $display("%0d ns: test %s had %0d errors", $time, name, error_count - errors_before);
    end
  endtask

  initial begin
    int errors_before;
    reset          = 1'b1;
    fetch_addr.raw = '0;
    force_refuse   = 1'b0;
    expect_hit     = 1'b0;
    error_count    = 0;
    test_count     = 0;
    next_cycle(reset_cycles);
    reset = 1'b0;

    errors_before = error_count;               // Address zero is the first miss.
    wait_for(cond_load, "first load after reset");
    wait_for(cond_valid, "first fill after reset");
    end_test("reset_state", errors_before);

    errors_before = error_count;
    next_cycle(1);
    fetch_addr.raw = addr_a;
    wait_for(cond_load, "cold miss load");
    wait_for(cond_valid, "cold miss fill");
    end_test("cold_miss", errors_before);

    errors_before = error_count;
    next_cycle(1);
    fetch_addr.raw = addr_b;
    wait_for(cond_valid, "fill of second line");
    next_cycle(1);
    fetch_addr.raw = addr_a;
    expect_hit     = 1'b1;
    next_cycle(4);
    expect_hit = 1'b0;
    end_test("hit", errors_before);

    errors_before = error_count;
    next_cycle(1);
    fetch_addr.raw = addr_c;                   // Same index, evicts the first line.
    wait_for(cond_load, "conflict miss load");
    wait_for(cond_valid, "conflict miss fill");
    next_cycle(1);
    fetch_addr.raw = addr_a;
    wait_for(cond_load, "refetch of evicted line");
    wait_for(cond_valid, "refill of evicted line");
    end_test("conflict", errors_before);

    errors_before = error_count;
    next_cycle(1);
    force_refuse   = 1'b1;
    fetch_addr.raw = addr_d;
    wait_for(cond_load, "load under refusal");
    next_cycle(6);
    force_refuse = 1'b0;
    wait_for(cond_valid, "fill after refusal");
    end_test("refusal", errors_before);

    errors_before = error_count;
    next_cycle(1);
    fetch_addr.raw = addr_e;
    wait_for(cond_grant, "grant of the line to abandon");
    next_cycle(1);
    fetch_addr.raw = addr_f;                   // Leaves before the data can return.
    wait_for(cond_valid, "fill of the new line");
    next_cycle(12);
    fetch_addr.raw = addr_e;
    wait_for(cond_load, "load of the abandoned line");
    wait_for(cond_valid, "fill of the abandoned line");
    end_test("abandon", errors_before);

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb_mem_model.sv
// Testbench memory model
module tb_mem_model
  import fetch_cache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         force_refuse,          // Refuse every load while high.
  input  mem_request_s mem_request,
  output mem_reply_s   mem_reply
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int drive_delay    = 2;          // Outputs change this long after the edge.
  localparam int refuse_percent = 25;         // Chance that a load is refused in a cycle.
  localparam int min_delay      = 2;          // Shortest reply delay in cycles.
  localparam int max_delay      = 9;

  logic [mem_tag_bits-1:0] grant_tag;         // Tag handed out with the next grant.
  logic [mem_tag_bits-1:0] grant_response;
  logic                    refuse_roll;       // Random refusal for the current cycle.
  logic [mem_tag_bits-1:0] return_tag;
  logic [line_bits-1:0]    return_data;
  logic [15:0]             pending;           // One bit per tag still in flight.
  logic [63:0]             pending_addr [16];
  int                      pending_due [16];  // Cycle in which the data comes back.
  int                      cycle;

  // Every line holds its own address scrambled by a fixed pattern.
  function automatic logic [63:0] line_content(input logic [63:0] addr);
    return addr ^ 64'h5a5a_0000_c3c3_0000;
  endfunction

  // A tag is only granted again once its data has gone back.
  assign grant_response = (!reset && (mem_request.command == bus_load) && !force_refuse &&
                           !refuse_roll && !pending[grant_tag]) ? grant_tag : '0;

  assign mem_reply = '{response: grant_response, data: return_data, tag: return_tag};

  initial begin
    logic                    accepted;
    logic [mem_tag_bits-1:0] accepted_tag;
    logic [63:0]             accepted_addr;
    logic                    in_reset;
    int                      found;
    int                      t;
    void'($urandom(32'h3dbf_cc56));           // Delays and refusals repeat from run to run.
    grant_tag   = 1;
    refuse_roll = 1'b0;
    return_tag  = '0;
    return_data = '0;
    pending     = '0;
    cycle       = 0;
    forever begin
      @(posedge clock);
      in_reset      = reset;                  // Everything here is what the DUT saw.
      accepted      = (mem_request.command == bus_load) && (grant_response != '0);
      accepted_tag  = grant_response;
      accepted_addr = mem_request.addr;
      #drive_delay;
      cycle++;
      if (in_reset) begin
        pending     = '0;
        grant_tag   = 1;
        refuse_roll = 1'b0;
        return_tag  = '0;
        return_data = '0;
      end else begin
        if (accepted) begin
          pending[accepted_tag]      = 1'b1;
          pending_addr[accepted_tag] = accepted_addr;
          pending_due[accepted_tag]  = cycle - 1 + $urandom_range(max_delay, min_delay);
          grant_tag = (grant_tag == '1) ? 1 : grant_tag + 1;  // Zero is never a tag.
        end
        found = 0;
        for (t = 1; t < 16; t++) begin
          if ((found == 0) && pending[t] && (pending_due[t] <= cycle)) begin
            found = t;
          end
        end
        return_tag  = found[mem_tag_bits-1:0];
        return_data = '0;
        if (found != 0) begin
          return_data    = line_content(pending_addr[found]);
          pending[found] = 1'b0;
        end
        refuse_roll = ($urandom_range(99) < refuse_percent);
      end
    end
  end

endmodule
